// ==== fir_bus_pkg.sv ====
// AHB-Lite bus side definitions for the FIR slave
// Address map, transfer codes and bus word types

package fir_bus_pkg;

  // ************************************************************
  // Bus word types
  // ************************************************************
  typedef logic [3:0]  haddr_t;
  typedef logic [15:0] hdata_t;
  typedef logic [1:0]  htrans_t;

  // Transfer type codes
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

  // ************************************************************
  // Register map, one halfword each
  // ************************************************************
  localparam haddr_t ADDR_STATUS     = 4'd0;
  localparam haddr_t ADDR_RESULT     = 4'd2;
  localparam haddr_t ADDR_SAMPLE     = 4'd4;
  // F0 here, F1..F3 follow every two bytes
  localparam haddr_t ADDR_COEF_START = 4'd6;
  localparam haddr_t ADDR_COEF_SET   = 4'd14;

endpackage

// ==== fir_dsp_pkg.sv ====
// FIR filter side definitions
// Tap count, fixed point formats and controller states

package fir_dsp_pkg;

  // Four taps, coefficients in Q1.15
  localparam int NUM_TAPS       = 4;
  localparam int COEF_FRAC_BITS = 15;

  // Unsigned input sample
  typedef logic [15:0] sample_t;
  // 16'h8000 is 1.0
  typedef logic [15:0] coeff_t;
  typedef logic [1:0]  tap_idx_t;
  // Room for two positive 32-bit products plus sign
  typedef logic signed [33:0] acc_t;

  // Controller sequence
  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    MAC,
    STORE
  } fir_state_t;

endpackage

// ==== ahb_slave_regs.sv ====
// AHB-Lite slave front end of the FIR block
// Registers the address phase, commits writes, muxes reads
// and flags illegal transfers through hresp

`timescale 1ns/1ns

module ahb_slave_regs (
  input  logic                 tb_clk,
  input  logic                 rst_n,
  // AHB-Lite bus
  input  logic                 hsel,
  input  fir_bus_pkg::haddr_t  haddr,
  input  fir_bus_pkg::htrans_t htrans,
  input  logic                 hwrite,
  input  fir_bus_pkg::hdata_t  hwdata,
  output fir_bus_pkg::hdata_t  hrdata,
  output logic                 hresp,
  // Filter status
  input  fir_dsp_pkg::sample_t fir_result,
  input  logic                 fir_err,
  input  logic                 fir_busy,
  input  logic                 load_busy,
  // Sample handshake
  output fir_dsp_pkg::sample_t sample_value,
  output logic                 sample_ready,
  input  logic                 sample_take,
  // Coefficients
  output fir_dsp_pkg::coeff_t  coeff0,
  output fir_dsp_pkg::coeff_t  coeff1,
  output fir_dsp_pkg::coeff_t  coeff2,
  output fir_dsp_pkg::coeff_t  coeff3,
  output logic                 new_coeff_set,
  input  logic                 coeff_done
);
  import fir_bus_pkg::*;
  import fir_dsp_pkg::*;

  haddr_t   addr_q;
  logic     write_q;
  logic     active_q;
  logic     hresp_q;
  logic     addr_valid;
  logic     addr_bad;
  logic     wr_commit;
  logic     is_coef;
  logic [2:0] coef_word;
  tap_idx_t coef_sel;
  sample_t  sample_q;
  coeff_t   coeff_q [NUM_TAPS];
  logic     coef_set_q;
  hdata_t   rdata;

  // ************************************************************
  // Address phase decode
  // ************************************************************
  assign addr_valid = hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
  // Odd addresses (15 included) and writes to read-only words
  assign addr_bad = haddr[0] ||
                    (hwrite && (haddr == ADDR_STATUS || haddr == ADDR_RESULT));

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q   <= '0;
      write_q  <= 1'b0;
      active_q <= 1'b0;
      hresp_q  <= 1'b0;
    end else begin
      addr_q   <= haddr;
      write_q  <= hwrite;
      // Only legal transfers reach the data phase logic
      active_q <= addr_valid && !addr_bad;
      hresp_q  <= addr_valid && addr_bad;
    end
  end

  assign hresp     = hresp_q;
  assign wr_commit = active_q && write_q;

  // Coefficient word index from the registered address
  assign is_coef   = (addr_q >= ADDR_COEF_START) && (addr_q < ADDR_COEF_SET);
  assign coef_word = addr_q[3:1] - ADDR_COEF_START[3:1];
  assign coef_sel  = coef_word[1:0];

  // ************************************************************
  // Write side registers
  // ************************************************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_q     <= '0;
      sample_ready <= 1'b0;
    end else if (wr_commit && addr_q == ADDR_SAMPLE) begin
      // Newest sample overwrites one not yet taken
      sample_q     <= hwdata;
      sample_ready <= 1'b1;
    end else if (sample_take) begin
      sample_ready <= 1'b0;
    end
  end

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        coeff_q[i] <= '0;
      end
    end else if (wr_commit && is_coef) begin
      coeff_q[coef_sel] <= hwdata;
    end
  end

  // Flag drops when the loader finishes, a new write takes priority
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_set_q <= 1'b0;
    end else if (wr_commit && addr_q == ADDR_COEF_SET) begin
      coef_set_q <= |hwdata;
    end else if (coeff_done) begin
      coef_set_q <= 1'b0;
    end
  end

  // ************************************************************
  // Read mux, data phase only
  // ************************************************************
  always_comb begin
    case (addr_q)
      ADDR_STATUS:   rdata = {7'b0, fir_err, 7'b0, (fir_busy | load_busy)};
      ADDR_RESULT:   rdata = fir_result;
      ADDR_SAMPLE:   rdata = sample_q;
      ADDR_COEF_SET: rdata = {15'b0, coef_set_q};
      default:       rdata = is_coef ? coeff_q[coef_sel] : '0;
    endcase
  end

  assign hrdata = (active_q && !write_q) ? rdata : '0;

  assign sample_value  = sample_q;
  assign coeff0        = coeff_q[0];
  assign coeff1        = coeff_q[1];
  assign coeff2        = coeff_q[2];
  assign coeff3        = coeff_q[3];
  assign new_coeff_set = coef_set_q;

endmodule

// ==== coeff_loader.sv ====
// Coefficient loader
// Walks the four coefficient registers into the filter bank,
// one tap per cycle, after a new set is flagged

`timescale 1ns/1ns

module coeff_loader (
  input  logic                   tb_clk,
  input  logic                   rst_n,
  input  logic                   new_coeff_set,
  input  fir_dsp_pkg::coeff_t    coeff0,
  input  fir_dsp_pkg::coeff_t    coeff1,
  input  fir_dsp_pkg::coeff_t    coeff2,
  input  fir_dsp_pkg::coeff_t    coeff3,
  output logic                   coeff_load,
  output fir_dsp_pkg::tap_idx_t  coeff_idx,
  output fir_dsp_pkg::coeff_t    coeff_value,
  output logic                   coeff_done,
  output logic                   load_busy
);
  import fir_dsp_pkg::*;

  logic     busy_q;
  tap_idx_t idx_q;
  logic     last_tap;

  assign last_tap = (idx_q == tap_idx_t'(NUM_TAPS - 1));

  // Start on the flag, stop after F3
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (busy_q) begin
      busy_q <= !last_tap;
      idx_q  <= last_tap ? '0 : idx_q + 1'b1;
    end else if (new_coeff_set) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end
  end

  // Select the current tap's register
  always_comb begin
    case (idx_q)
      2'd0:    coeff_value = coeff0;
      2'd1:    coeff_value = coeff1;
      2'd2:    coeff_value = coeff2;
      default: coeff_value = coeff3;
    endcase
  end

  assign coeff_load = busy_q;
  assign coeff_idx  = idx_q;
  // Pulses with the last tap, slave drops the flag on this edge
  assign coeff_done = busy_q && last_tap;
  assign load_busy  = busy_q;

endmodule

// ==== fir_controller.sv ====
// FIR sequencer
// Accepts one sample at a time, then runs shift, four MAC steps
// and a store of the saturated result

`timescale 1ns/1ns

module fir_controller (
  input  logic                  tb_clk,
  input  logic                  rst_n,
  input  logic                  sample_ready,
  input  logic                  load_busy,
  output logic                  sample_take,
  output logic                  shift_en,
  output logic                  mac_en,
  output fir_dsp_pkg::tap_idx_t tap_idx,
  output logic                  store_en,
  output logic                  fir_busy
);
  import fir_dsp_pkg::*;

  fir_state_t state_q;
  fir_state_t state_d;
  tap_idx_t   tap_q;
  logic       accept;
  logic       last_tap;

  // No new sample while coefficients are moving
  assign accept   = (state_q == IDLE) && sample_ready && !load_busy;
  assign last_tap = (tap_q == tap_idx_t'(NUM_TAPS - 1));

  // ************************************************************
  // Next state
  // ************************************************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = SHIFT;
      SHIFT:   state_d = MAC;
      MAC:     if (last_tap) state_d = STORE;
      STORE:   state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      tap_q   <= '0;
    end else begin
      state_q <= state_d;
      // Tap counter only runs inside MAC
      tap_q   <= (state_q == MAC && !last_tap) ? tap_q + 1'b1 : '0;
    end
  end

  // Strobes decoded straight from state
  assign sample_take = accept;
  assign shift_en    = (state_q == SHIFT);
  assign mac_en      = (state_q == MAC);
  assign tap_idx     = tap_q;
  assign store_en    = (state_q == STORE);
  assign fir_busy    = (state_q != IDLE);

endmodule

// ==== fir_datapath.sv ====
// FIR datapath
// Sample history, coefficient bank, alternating sign accumulator
// and Q1.15 scaling with saturation to the unsigned range

`timescale 1ns/1ns

module fir_datapath (
  input  logic                  tb_clk,
  input  logic                  rst_n,
  input  fir_dsp_pkg::sample_t  sample_value,
  input  logic                  shift_en,
  input  logic                  mac_en,
  input  fir_dsp_pkg::tap_idx_t tap_idx,
  input  logic                  store_en,
  input  logic                  coeff_load,
  input  fir_dsp_pkg::tap_idx_t coeff_idx,
  input  fir_dsp_pkg::coeff_t   coeff_value,
  output fir_dsp_pkg::sample_t  fir_result,
  output logic                  fir_err
);
  import fir_dsp_pkg::*;

  sample_t     hist [NUM_TAPS];
  coeff_t      bank [NUM_TAPS];
  acc_t        acc_q;
  logic [31:0] prod;
  acc_t        term;
  acc_t        scaled;

  // ************************************************************
  // History and coefficient bank
  // ************************************************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        hist[i] <= '0;
        bank[i] <= '0;
      end
    end else begin
      // x0 is always the newest sample
      if (shift_en) begin
        hist[0] <= sample_value;
        for (int i = 1; i < NUM_TAPS; i++) begin
          hist[i] <= hist[i-1];
        end
      end
      if (coeff_load) begin
        bank[coeff_idx] <= coeff_value;
      end
    end
  end

  // ************************************************************
  // Multiply-accumulate
  // ************************************************************
  assign prod = hist[tap_idx] * bank[tap_idx];
  // Product is never negative, zero extend into the accumulator
  assign term = {2'b00, prod};

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (shift_en) begin
      acc_q <= '0;
    end else if (mac_en) begin
      // Odd taps subtract
      acc_q <= tap_idx[0] ? acc_q - term : acc_q + term;
    end
  end

  // Drop the fraction bits, sign kept
  assign scaled = acc_q >>> COEF_FRAC_BITS;

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      fir_result <= '0;
      fir_err    <= 1'b0;
    end else if (store_en) begin
      if (acc_q < 0) begin
        fir_result <= '0;
        fir_err    <= 1'b1;
      end else if (|scaled[$bits(acc_t)-1:16]) begin
        // Above 16'hFFFF
        fir_result <= '1;
        fir_err    <= 1'b1;
      end else begin
        fir_result <= scaled[15:0];
        fir_err    <= 1'b0;
      end
    end
  end

endmodule

// ==== ahb_fir_top.sv ====
// AHB-Lite FIR filter top level
// Bus slave, coefficient loader, sequencer and datapath

`timescale 1ns/1ns

module ahb_fir_top (
  input  logic                 tb_clk,
  input  logic                 rst_n,
  input  logic                 hsel,
  input  fir_bus_pkg::haddr_t  haddr,
  input  fir_bus_pkg::htrans_t htrans,
  input  logic                 hwrite,
  input  fir_bus_pkg::hdata_t  hwdata,
  output fir_bus_pkg::hdata_t  hrdata,
  output logic                 hresp
);
  import fir_dsp_pkg::*;

  // Sample path
  sample_t  sample_value;
  logic     sample_ready;
  logic     sample_take;
  sample_t  fir_result;
  logic     fir_err;
  logic     fir_busy;
  // Coefficient path
  coeff_t   coeff0;
  coeff_t   coeff1;
  coeff_t   coeff2;
  coeff_t   coeff3;
  logic     new_coeff_set;
  logic     coeff_done;
  logic     coeff_load;
  tap_idx_t coeff_idx;
  coeff_t   coeff_value;
  logic     load_busy;
  // Sequencer strobes
  logic     shift_en;
  logic     mac_en;
  tap_idx_t tap_idx;
  logic     store_en;

  ahb_slave_regs u_slave (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .hsel(hsel), .haddr(haddr), .htrans(htrans), .hwrite(hwrite),
    .hwdata(hwdata), .hrdata(hrdata), .hresp(hresp),
    .fir_result(fir_result), .fir_err(fir_err),
    .fir_busy(fir_busy), .load_busy(load_busy),
    .sample_value(sample_value), .sample_ready(sample_ready),
    .sample_take(sample_take),
    .coeff0(coeff0), .coeff1(coeff1), .coeff2(coeff2), .coeff3(coeff3),
    .new_coeff_set(new_coeff_set), .coeff_done(coeff_done)
  );

  coeff_loader u_loader (
    .tb_clk(tb_clk), .rst_n(rst_n), .new_coeff_set(new_coeff_set),
    .coeff0(coeff0), .coeff1(coeff1), .coeff2(coeff2), .coeff3(coeff3),
    .coeff_load(coeff_load), .coeff_idx(coeff_idx),
    .coeff_value(coeff_value), .coeff_done(coeff_done), .load_busy(load_busy)
  );

  fir_controller u_ctrl (
    .tb_clk(tb_clk), .rst_n(rst_n),
    .sample_ready(sample_ready), .load_busy(load_busy),
    .sample_take(sample_take), .shift_en(shift_en), .mac_en(mac_en),
    .tap_idx(tap_idx), .store_en(store_en), .fir_busy(fir_busy)
  );

  fir_datapath u_dp (
    .tb_clk(tb_clk), .rst_n(rst_n), .sample_value(sample_value),
    .shift_en(shift_en), .mac_en(mac_en), .tap_idx(tap_idx),
    .store_en(store_en), .coeff_load(coeff_load), .coeff_idx(coeff_idx),
    .coeff_value(coeff_value), .fir_result(fir_result), .fir_err(fir_err)
  );

endmodule

// ==== ahb_fir_chk.sv ====
// Bus response and sequencer checks for the FIR slave
// Bound into the top level

`timescale 1ns/1ns

module ahb_fir_chk (
  input logic                 tb_clk,
  input logic                 rst_n,
  input logic                 hsel,
  input fir_bus_pkg::htrans_t htrans,
  input logic                 hresp,
  input logic                 fir_busy
);
  import fir_bus_pkg::*;

  logic [3:0] busy_run;

  // Length of the current busy stretch
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_run <= '0;
    end else if (fir_busy) begin
      busy_run <= busy_run + 4'd1;
    end else begin
      busy_run <= '0;
    end
  end

  // Error response only in the data phase of an active transfer
  assert property (@(posedge tb_clk) disable iff (!rst_n)
    hresp |-> $past(hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ)))
    else $error("hresp high without a valid address phase");

  assert property (@(posedge tb_clk) $rose(rst_n) |-> !hresp)
    else $error("hresp high in the cycle after reset");

  // Shift, four MAC steps and store
  assert property (@(posedge tb_clk) disable iff (!rst_n) busy_run <= 4'd6)
    else $error("fir_busy held longer than 6 cycles");

endmodule

bind ahb_fir_top ahb_fir_chk u_chk (
  .tb_clk(tb_clk), .rst_n(rst_n), .hsel(hsel), .htrans(htrans),
  .hresp(hresp), .fir_busy(fir_busy)
);

// ==== tb_ahb_fir.sv ====
// Testbench for the AHB-Lite FIR slave
// Builds a transfer table from a register and filter model,
// then drives it over the bus and checks every data phase

`timescale 1ns/1ns

module tb_ahb_fir;
  import fir_bus_pkg::*;

  // One bus transfer with its expected response
  typedef struct packed {
    logic [2:0] grp;
    logic       wr;
    haddr_t     addr;
    hdata_t     data;
    hdata_t     exp_rdata;
    logic       exp_resp;
    logic [3:0] idle;
  } row_t;

  localparam int          NUM_GROUPS = 6;
  localparam logic [31:0] LCG_SEED   = 32'hfe79848a;

  logic    tb_clk = 1'b0;
  logic    rst_n;
  logic    hsel;
  haddr_t  haddr;
  htrans_t htrans;
  logic    hwrite;
  hdata_t  hwdata;
  hdata_t  hrdata;
  logic    hresp;

  row_t        tbl [$];
  string       grp_name [NUM_GROUPS];
  int          cycles = 0;
  int          limit = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          grp_errors = 0;
  logic [31:0] lcg_state = LCG_SEED;

  // Register map and filter model
  hdata_t m_sample;
  hdata_t m_coef [4];
  hdata_t m_bank [4];
  hdata_t m_hist [4];
  hdata_t m_result;
  logic   m_err;

  ahb_fir_top u_dut (
    .tb_clk(tb_clk), .rst_n(rst_n), .hsel(hsel), .haddr(haddr),
    .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata),
    .hrdata(hrdata), .hresp(hresp)
  );

  // 8 ns clock
  always begin
    tb_clk = 1'b0;
    #4;
    tb_clk = 1'b1;
    #4;
  end

  // Run limit is set once the table length is known
  always @(posedge tb_clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ************************************************************
  // Reference model of the alternating sign filter
  // ************************************************************
  task automatic run_filter(input hdata_t x);
    longint acc;
    longint scaled;
    for (int i = 3; i > 0; i--) begin
      m_hist[i] = m_hist[i-1];
    end
    m_hist[0] = x;
    acc = 0;
    for (int i = 0; i < 4; i++) begin
      if (i % 2 == 0) begin
        acc = acc + longint'(m_hist[i]) * longint'(m_bank[i]);
      end else begin
        acc = acc - longint'(m_hist[i]) * longint'(m_bank[i]);
      end
    end
    scaled = acc >>> 15;
    // Either clamp to the unsigned range sets err
    if (acc < 0) begin
      m_result = '0;
      m_err    = 1'b1;
    end else if (scaled > 64'sd65535) begin
      m_result = 16'hffff;
      m_err    = 1'b1;
    end else begin
      m_result = scaled[15:0];
      m_err    = 1'b0;
    end
  endtask

  // Read value of a legal even address
  function automatic hdata_t read_model(input haddr_t a);
    int k;
    k = (int'(a) - int'(ADDR_COEF_START)) / 2;
    case (a)
      ADDR_STATUS:   return {7'b0, m_err, 8'b0};
      ADDR_RESULT:   return m_result;
      ADDR_SAMPLE:   return m_sample;
      // Flag is cleared by the loader well before any read
      ADDR_COEF_SET: return '0;
      default:       return m_coef[k];
    endcase
  endfunction

  // Append one transfer and update the model with its effect
  task automatic add_row(input logic [2:0] grp, input logic wr, input haddr_t a,
                         input hdata_t d);
    logic       bad;
    hdata_t     exp_rd;
    logic [3:0] idle;
    int         k;
    // Writes to status or result, odd addresses and address 15
    bad    = (wr && a == ADDR_STATUS) || (wr && a == ADDR_RESULT) ||
             a[0] || a == 4'd15;
    exp_rd = (bad || wr) ? '0 : read_model(a);
    idle   = 4'd1;
    k      = (int'(a) - int'(ADDR_COEF_START)) / 2;
    if (wr && !bad) begin
      if (a == ADDR_SAMPLE) begin
        m_sample = d;
        run_filter(d);
        idle = 4'd10;
      end else if (a == ADDR_COEF_SET) begin
        // Nonzero flag copies the registers into the bank
        if (d != '0) begin
          m_bank = m_coef;
        end
        idle = 4'd8;
      end else if (a > ADDR_SAMPLE) begin
        m_coef[k] = d;
      end
    end
    tbl.push_back('{grp, wr, a, d, exp_rd, bad, idle});
  endtask

  task automatic load_coeffs(input logic [2:0] grp, input hdata_t c0, input hdata_t c1,
                             input hdata_t c2, input hdata_t c3);
    add_row(grp, 1'b1, 4'd6, c0);
    add_row(grp, 1'b1, 4'd8, c1);
    add_row(grp, 1'b1, 4'd10, c2);
    add_row(grp, 1'b1, 4'd12, c3);
    add_row(grp, 1'b1, ADDR_COEF_SET, 16'h0001);
  endtask

  // Sample write followed by result and status reads
  task automatic send_sample(input logic [2:0] grp, input hdata_t x);
    add_row(grp, 1'b1, ADDR_SAMPLE, x);
    add_row(grp, 1'b0, ADDR_RESULT, '0);
    add_row(grp, 1'b0, ADDR_STATUS, '0);
  endtask

  task automatic build_table();
    hdata_t rc [4];
    grp_name = '{"reset", "coeff load", "filter", "saturation", "bus error", "random"};
    m_sample = '0;
    m_result = '0;
    m_err    = 1'b0;
    for (int i = 0; i < 4; i++) begin
      m_coef[i] = '0;
      m_bank[i] = '0;
      m_hist[i] = '0;
    end
    // Every even address reads 0 after reset
    for (int a = 0; a <= 14; a += 2) begin
      add_row(3'd0, 1'b0, haddr_t'(a), '0);
    end
    // Write and load the coefficients and read them back
    load_coeffs(3'd1, 16'h4000, 16'h8000, 16'h8000, 16'h4000);
    for (int a = 6; a <= 12; a += 2) begin
      add_row(3'd1, 1'b0, haddr_t'(a), '0);
    end
    add_row(3'd1, 1'b0, ADDR_COEF_SET, '0);
    add_row(3'd1, 1'b0, ADDR_STATUS, '0);
    send_sample(3'd2, 16'd100);
    send_sample(3'd2, 16'd1000);
    send_sample(3'd2, 16'd1000);
    send_sample(3'd2, 16'd3000);
    // Negative sum followed by exact full scale and over range
    load_coeffs(3'd3, 16'h0000, 16'h8000, 16'h0000, 16'h0000);
    send_sample(3'd3, 16'h1234);
    load_coeffs(3'd3, 16'h8000, 16'h0000, 16'h0000, 16'h0000);
    send_sample(3'd3, 16'hffff);
    load_coeffs(3'd3, 16'hffff, 16'h0000, 16'h0000, 16'h0000);
    send_sample(3'd3, 16'hffff);
    // Illegal transfers leave every register unchanged
    add_row(3'd4, 1'b1, ADDR_STATUS, 16'hffff);
    add_row(3'd4, 1'b1, ADDR_RESULT, 16'h1234);
    add_row(3'd4, 1'b0, 4'd15, '0);
    add_row(3'd4, 1'b1, 4'd7, 16'h5555);
    add_row(3'd4, 1'b0, ADDR_STATUS, '0);
    add_row(3'd4, 1'b0, ADDR_RESULT, '0);
    add_row(3'd4, 1'b0, ADDR_SAMPLE, '0);
    add_row(3'd4, 1'b0, 4'd6, '0);
    add_row(3'd4, 1'b0, 4'd8, '0);
    for (int i = 0; i < 4; i++) begin
      rc[i] = hdata_t'(lcg_next() >> 16);
    end
    load_coeffs(3'd5, rc[0], rc[1], rc[2], rc[3]);
    for (int n = 0; n < 12; n++) begin
      send_sample(3'd5, hdata_t'(lcg_next() >> 16));
    end
  endtask

  // ************************************************************
  // Bus driver that starts and ends on a falling edge
  // ************************************************************
  task automatic apply_row(input row_t r);
    // Address phase
    hsel   = 1'b1;
    haddr  = r.addr;
    htrans = HTRANS_NONSEQ;
    hwrite = r.wr;
    @(negedge tb_clk);
    // Data phase
    hsel   = 1'b0;
    haddr  = '0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hwdata = r.wr ? r.data : '0;
    n_checks = n_checks + 2;
    if (hresp !== r.exp_resp) begin
      $display("ERR hresp addr %h: got %h exp %h", r.addr, hresp, r.exp_resp);
      n_errors++;
      grp_errors++;
    end
    if (hrdata !== r.exp_rdata) begin
      $display("ERR hrdata addr %h: got %h exp %h", r.addr, hrdata, r.exp_rdata);
      n_errors++;
      grp_errors++;
    end
    repeat (r.idle) @(negedge tb_clk);
    hwdata = '0;
  endtask

  initial begin
    hsel   = 1'b0;
    haddr  = '0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hwdata = '0;
    rst_n  = 1'b0;
    build_table();
    // No row needs more than 16 cycles
    limit = tbl.size() * 16 + 200;
    repeat (3) @(negedge tb_clk);
    rst_n = 1'b1;
    @(negedge tb_clk);
    for (int i = 0; i < tbl.size(); i++) begin
      apply_row(tbl[i]);
      // A group ends at the last row or where the next one starts
      if (i == tbl.size() - 1 || tbl[i+1].grp != tbl[i].grp) begin
        $display("test %0d %s: %s, %0d errors", tbl[i].grp + 1, grp_name[tbl[i].grp],
                 grp_errors == 0 ? "ok" : "failed", grp_errors);
        grp_errors = 0;
      end
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
fir_bus_pkg.sv
fir_dsp_pkg.sv
ahb_slave_regs.sv
coeff_loader.sv
fir_controller.sv
fir_datapath.sv
ahb_fir_top.sv
ahb_fir_chk.sv
tb_ahb_fir.sv

// ==== Makefile ====
# Verilator build and run of the AHB-Lite FIR testbench

VERILATOR ?= verilator
TOP       ?= tb_ahb_fir
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
